/* Bender.yml */
package:
  name: can_ctrl

sources:
  - files:
      - can_pkg.sv
      - can_crc15.sv
      - can_regs.sv
      - can_btl.sv
      - can_bit_tx.sv
      - can_bit_rx.sv
      - can_top.sv
  - target: test
    files:
      - can_tb.sv

/* can_bit_rx.sv */
//////////////////////////////
// CAN frame receiver
// Captures data and CRC-15 at sample points,
// flags frame done and CRC match
//////////////////////////////

`timescale 1ns/100ps

module can_bit_rx (
  input  logic           clk_i,
  input  logic           rst,
  input  logic           sample_point_i,
  input  logic           sampled_bit_i,
  input  can_pkg::len_t  frame_len_i,
  input  logic           rx_release_i,
  output logic           rx_busy_o,
  output logic           rx_done_o,
  output logic           crc_ok_o,
  output can_pkg::data_t rx_data_o,
  output can_pkg::crc_t  rx_crc_o
);

  typedef enum logic [1:0] {RX_IDLE, RX_DATA, RX_CRC} rx_state_e;

  rx_state_e     state;
  can_pkg::len_t bit_cnt;
  can_pkg::crc_t crc;
  can_pkg::crc_t crc_next;
  logic          start_bit;
  logic          crc_en;

  // Dominant sample on an idle, released receiver
  assign start_bit = (state == RX_IDLE) && !rx_done_o && sample_point_i && !sampled_bit_i;
  assign crc_en    = (state == RX_DATA) && sample_point_i;
  // CRC field including the bit now sampled
  assign crc_next  = {rx_crc_o[can_pkg::CRC_W-2:0], sampled_bit_i};

  can_crc15 i_can_crc15 (
    .clk_i   (clk_i),
    .rst     (rst),
    .clear_i (start_bit),
    .en_i    (crc_en),
    .bit_i   (sampled_bit_i),
    .crc_o   (crc)
  );

  //////////////////////////////
  // Receive FSM
  //////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      state     <= RX_IDLE;
      bit_cnt   <= '0;
      rx_busy_o <= 1'b0;
      rx_done_o <= 1'b0;
      crc_ok_o  <= 1'b0;
      rx_data_o <= '0;
      rx_crc_o  <= '0;
    end
    else
    begin
      if (rx_release_i)
        rx_done_o <= 1'b0;
      case (state)
        RX_IDLE:
          if (start_bit)
          begin
            // Clear data so a short frame lands right-aligned
            rx_data_o <= '0;
            rx_crc_o  <= '0;
            crc_ok_o  <= 1'b0;
            rx_busy_o <= 1'b1;
            bit_cnt   <= frame_len_i;
            state     <= RX_DATA;
          end
        RX_DATA:
          if (sample_point_i)
          begin
            rx_data_o <= {rx_data_o[can_pkg::MAX_DATA_BITS-2:0], sampled_bit_i};
            if (bit_cnt == can_pkg::LEN_W'(1))
            begin
              bit_cnt <= can_pkg::LEN_W'(can_pkg::CRC_W);
              state   <= RX_CRC;
            end
            else
              bit_cnt <= bit_cnt - 1'b1;
          end
        default:
          if (sample_point_i)
          begin
            rx_crc_o <= crc_next;
            bit_cnt  <= bit_cnt - 1'b1;
            // Last CRC bit ends the frame
            if (bit_cnt == can_pkg::LEN_W'(1))
            begin
              rx_busy_o <= 1'b0;
              rx_done_o <= 1'b1;
              crc_ok_o  <= (crc_next == crc);
              state     <= RX_IDLE;
            end
          end
      endcase
    end
  end

endmodule

/* can_bit_tx.sv */
//////////////////////////////
// CAN frame transmitter
// Start bit, data MSB first, then CRC-15,
// one bit per transmit point
//////////////////////////////

`timescale 1ns/100ps

module can_bit_tx (
  input  logic           clk_i,
  input  logic           rst,
  input  logic           tx_request_i,
  input  logic           tx_point_i,
  input  can_pkg::len_t  frame_len_i,
  input  can_pkg::data_t tx_data_i,
  output logic           tx_o,
  output logic           tx_busy_o
);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_CRC} tx_state_e;

  tx_state_e     state;
  // Bits left in the current field
  can_pkg::len_t bit_cnt;
  can_pkg::len_t cnt_m1;
  can_pkg::crc_t crc;
  logic          data_bit;
  logic          crc_clr;
  logic          crc_en;

  assign cnt_m1   = bit_cnt - 1'b1;
  assign data_bit = tx_data_i[cnt_m1[$clog2(can_pkg::MAX_DATA_BITS)-1:0]];

  // Fresh CRC per frame, fed with each data bit on the wire
  assign crc_clr = (state == TX_IDLE) && tx_request_i;
  assign crc_en  = (state == TX_DATA) && tx_point_i;

  can_crc15 i_can_crc15 (
    .clk_i   (clk_i),
    .rst     (rst),
    .clear_i (crc_clr),
    .en_i    (crc_en),
    .bit_i   (data_bit),
    .crc_o   (crc)
  );

  //////////////////////////////
  // Transmit FSM
  //////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      state     <= TX_IDLE;
      bit_cnt   <= '0;
      tx_o      <= 1'b1;
      tx_busy_o <= 1'b0;
    end
    else
    begin
      case (state)
        TX_IDLE:
          if (tx_request_i)
          begin
            state     <= TX_START;
            tx_busy_o <= 1'b1;
          end
        // Dominant start bit
        TX_START:
          if (tx_point_i)
          begin
            tx_o    <= 1'b0;
            bit_cnt <= frame_len_i;
            state   <= TX_DATA;
          end
        TX_DATA:
          if (tx_point_i)
          begin
            tx_o <= data_bit;
            if (bit_cnt == can_pkg::LEN_W'(1))
            begin
              bit_cnt <= can_pkg::LEN_W'(can_pkg::CRC_W);
              state   <= TX_CRC;
            end
            else
              bit_cnt <= cnt_m1;
          end
        // CRC is final here, shift it out MSB first
        default:
          if (tx_point_i)
          begin
            if (bit_cnt == '0)
            begin
              tx_o      <= 1'b1;
              tx_busy_o <= 1'b0;
              state     <= TX_IDLE;
            end
            else
            begin
              tx_o    <= crc[cnt_m1[$clog2(can_pkg::CRC_W)-1:0]];
              bit_cnt <= cnt_m1;
            end
          end
      endcase
    end
  end

endmodule

/* can_btl.sv */
//////////////////////////////
// CAN bit timing logic
// RX synchronizer, quantum prescaler, segment
// counter, sample/transmit strobes, hard sync
//////////////////////////////

`timescale 1ns/100ps

module can_btl #(
  parameter int SYNC_STAGES = 2
) (
  input  logic            clk_i,
  input  logic            rst,
  input  logic            rx_i,
  input  logic            reset_mode_i,
  input  can_pkg::presc_t presc_i,
  input  can_pkg::seg_t   prop_seg_i,
  input  can_pkg::seg_t   phase_seg_1_i,
  input  can_pkg::seg_t   phase_seg_2_i,
  input  logic            tx_busy_i,
  input  logic            rx_busy_i,
  output logic            rx_sync_o,
  output logic            sample_point_o,
  output logic            sampled_bit_o,
  output logic            tx_point_o
);

  // Segments in bit order
  typedef enum logic [1:0] {SEG_SYNC, SEG_PROP, SEG_PH1, SEG_PH2} seg_e;

  logic [SYNC_STAGES-1:0] sync_q;
  logic                   rx_prev;
  logic                   hard_sync;
  logic                   hs_restart;
  can_pkg::presc_t        clk_cnt;
  can_pkg::seg_t          q_cnt;
  can_pkg::seg_t          seg_len;
  seg_e                   seg;
  logic                   quant_end;
  logic                   seg_end;

  //////////////////////////////
  // Receive synchronizer
  //////////////////////////////
  // Chain idles recessive
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      sync_q  <= '1;
      rx_prev <= 1'b1;
    end
    else
    begin
      sync_q[0] <= rx_i;
      for (int i = 1; i < SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
      rx_prev <= rx_sync_o;
    end
  end

  assign rx_sync_o     = sync_q[SYNC_STAGES-1];
  assign sampled_bit_o = rx_sync_o;

  // Falling edge on an idle bus
  assign hard_sync = !tx_busy_i && !rx_busy_i && rx_prev && !rx_sync_o;

  // Last quantum index of the current segment
  always_comb
  begin
    case (seg)
      SEG_PROP: seg_len = prop_seg_i;
      SEG_PH1:  seg_len = phase_seg_1_i;
      SEG_PH2:  seg_len = phase_seg_2_i;
      default:  seg_len = '0;
    endcase
  end

  assign quant_end = (clk_cnt == presc_i);
  assign seg_end   = quant_end && (q_cnt == seg_len);

  //////////////////////////////
  // Quantum and segment counters
  //////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      clk_cnt    <= '0;
      q_cnt      <= '0;
      seg        <= SEG_SYNC;
      hs_restart <= 1'b0;
    end
    else
    begin
      // Flags the restarted sync quantum
      hs_restart <= hard_sync;
      if (reset_mode_i || hard_sync)
      begin
        clk_cnt <= '0;
        q_cnt   <= '0;
        seg     <= SEG_SYNC;
      end
      else if (quant_end)
      begin
        clk_cnt <= '0;
        if (seg_end)
        begin
          q_cnt <= '0;
          // Phase 2 wraps back to sync
          seg   <= seg_e'(seg + 2'd1);
        end
        else
          q_cnt <= q_cnt + 1'b1;
      end
      else
        clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // First clock of sync quantum, skipped after hard sync
  assign tx_point_o = !reset_mode_i && (seg == SEG_SYNC) && (clk_cnt == '0) && !hs_restart;
  // Last clock of phase segment 1, void when hard sync restarts the bit
  assign sample_point_o = (seg == SEG_PH1) && seg_end && !hard_sync;

endmodule

/* can_crc15.sv */
//////////////////////////////
// CAN CRC-15 generator
// Serial, one bit per enable
//////////////////////////////

`timescale 1ns/100ps

module can_crc15 (
  input  logic          clk_i,
  input  logic          rst,
  input  logic          clear_i,
  input  logic          en_i,
  input  logic          bit_i,
  output can_pkg::crc_t crc_o
);

  logic fb;

  // Feedback is incoming bit against the MSB
  assign fb = bit_i ^ crc_o[can_pkg::CRC_W-1];

  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
      crc_o <= '0;
    else if (clear_i)
      crc_o <= '0;
    else if (en_i)
      crc_o <= {crc_o[can_pkg::CRC_W-2:0], 1'b0} ^ (can_pkg::CRC_POLY & {can_pkg::CRC_W{fb}});
  end

endmodule

/* can_pkg.sv */
//////////////////////////////
// CAN controller package
// Register map, field widths, CRC-15
// constants and shared vector types
//////////////////////////////

package can_pkg;

  // Register port widths
  localparam int REG_ADDR_W = 8;
  localparam int REG_DATA_W = 32;

  //////////////////////////////
  // Register map, one word per address
  //////////////////////////////
  localparam logic [REG_ADDR_W-1:0] ADDR_MODE   = 8'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_CMD    = 8'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS = 8'd2;
  localparam logic [REG_ADDR_W-1:0] ADDR_BTR    = 8'd3;
  localparam logic [REG_ADDR_W-1:0] ADDR_LEN    = 8'd4;
  localparam logic [REG_ADDR_W-1:0] ADDR_TX_LO  = 8'd5;
  localparam logic [REG_ADDR_W-1:0] ADDR_TX_HI  = 8'd6;
  localparam logic [REG_ADDR_W-1:0] ADDR_RX_LO  = 8'd7;
  localparam logic [REG_ADDR_W-1:0] ADDR_RX_HI  = 8'd8;
  localparam logic [REG_ADDR_W-1:0] ADDR_RX_CRC = 8'd9;

  // Mode, command and status bit positions
  localparam int MODE_RESET_BIT     = 0;
  localparam int MODE_IRQ_EN_BIT    = 1;
  localparam int CMD_TX_REQ_BIT     = 0;
  localparam int CMD_RX_RELEASE_BIT = 1;
  localparam int STATUS_TX_BUSY_BIT = 0;
  localparam int STATUS_RX_BUSY_BIT = 1;
  localparam int STATUS_RX_DONE_BIT = 2;
  localparam int STATUS_CRC_OK_BIT  = 3;

  //////////////////////////////
  // Bit timing fields
  //////////////////////////////
  localparam int PRESC_W = 7;
  localparam int SEG_W   = 6;
  // Field positions inside the BTR word
  localparam int BTR_PRESC_LSB = 0;
  localparam int BTR_PROP_LSB  = 8;
  localparam int BTR_PH1_LSB   = 16;
  localparam int BTR_PH2_LSB   = 24;

  // Frame data field
  localparam int MAX_DATA_BITS = 64;
  localparam int LEN_W         = 7;

  // CAN CRC-15, initial value zero
  localparam int                CRC_W    = 15;
  localparam logic [CRC_W-1:0]  CRC_POLY = 15'h4599;

  typedef logic [PRESC_W-1:0]       presc_t;
  typedef logic [SEG_W-1:0]         seg_t;
  typedef logic [LEN_W-1:0]         len_t;
  typedef logic [CRC_W-1:0]         crc_t;
  typedef logic [MAX_DATA_BITS-1:0] data_t;

endpackage

/* can_regs.sv */
//////////////////////////////
// CAN register block
// Mode, command, timing, length and TX data
// registers with a registered read mux
//////////////////////////////

`timescale 1ns/100ps

module can_regs (
  input  logic                             clk_i,
  input  logic                             rst,
  // Register port
  input  logic                             reg_re_i,
  input  logic                             reg_we_i,
  input  logic [can_pkg::REG_ADDR_W-1:0]   reg_addr_i,
  input  logic [can_pkg::REG_DATA_W-1:0]   reg_data_i,
  output logic [can_pkg::REG_DATA_W-1:0]   reg_data_o,
  // Status from bit-stream logic
  input  logic                             tx_busy_i,
  input  logic                             rx_busy_i,
  input  logic                             rx_done_i,
  input  logic                             crc_ok_i,
  input  can_pkg::data_t                   rx_data_i,
  input  can_pkg::crc_t                    rx_crc_i,
  // Configuration levels
  output logic                             reset_mode_o,
  output can_pkg::presc_t                  presc_o,
  output can_pkg::seg_t                    prop_seg_o,
  output can_pkg::seg_t                    phase_seg_1_o,
  output can_pkg::seg_t                    phase_seg_2_o,
  output can_pkg::len_t                    frame_len_o,
  output can_pkg::data_t                   tx_data_o,
  // Command pulses
  output logic                             tx_request_o,
  output logic                             rx_release_o,
  output logic                             irq_o
);

  logic                           irq_en;
  logic                           cmd_wr;
  logic                           tx_wr_ok;
  logic [can_pkg::REG_DATA_W-1:0] rdata;

  // Commands only count outside reset mode
  assign cmd_wr   = reg_we_i && (reg_addr_i == can_pkg::ADDR_CMD) && !reset_mode_o;
  // TX data is free while reset mode or no frame in flight
  assign tx_wr_ok = reset_mode_o || !tx_busy_i;

  // Interrupt follows the done flag
  assign irq_o = rx_done_i & irq_en;

  //////////////////////////////
  // Mode register
  //////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      reset_mode_o <= 1'b1;
      irq_en       <= 1'b0;
    end
    else if (reg_we_i && (reg_addr_i == can_pkg::ADDR_MODE))
    begin
      reset_mode_o <= reg_data_i[can_pkg::MODE_RESET_BIT];
      irq_en       <= reg_data_i[can_pkg::MODE_IRQ_EN_BIT];
    end
  end

  // Timing and length, locked outside reset mode
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      presc_o       <= '0;
      prop_seg_o    <= '0;
      phase_seg_1_o <= '0;
      phase_seg_2_o <= '0;
      frame_len_o   <= '0;
    end
    else if (reg_we_i && reset_mode_o)
    begin
      if (reg_addr_i == can_pkg::ADDR_BTR)
      begin
        presc_o       <= reg_data_i[can_pkg::BTR_PRESC_LSB +: can_pkg::PRESC_W];
        prop_seg_o    <= reg_data_i[can_pkg::BTR_PROP_LSB  +: can_pkg::SEG_W];
        phase_seg_1_o <= reg_data_i[can_pkg::BTR_PH1_LSB   +: can_pkg::SEG_W];
        phase_seg_2_o <= reg_data_i[can_pkg::BTR_PH2_LSB   +: can_pkg::SEG_W];
      end
      if (reg_addr_i == can_pkg::ADDR_LEN)
        frame_len_o <= reg_data_i[can_pkg::LEN_W-1:0];
    end
  end

  // Transmit data, low and high words
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
      tx_data_o <= '0;
    else if (reg_we_i && tx_wr_ok)
    begin
      if (reg_addr_i == can_pkg::ADDR_TX_LO)
        tx_data_o[can_pkg::REG_DATA_W-1:0] <= reg_data_i;
      if (reg_addr_i == can_pkg::ADDR_TX_HI)
        tx_data_o[can_pkg::MAX_DATA_BITS-1:can_pkg::REG_DATA_W] <= reg_data_i;
    end
  end

  // Command decode, one-cycle pulses
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      tx_request_o <= 1'b0;
      rx_release_o <= 1'b0;
    end
    else
    begin
      tx_request_o <= cmd_wr & reg_data_i[can_pkg::CMD_TX_REQ_BIT];
      rx_release_o <= cmd_wr & reg_data_i[can_pkg::CMD_RX_RELEASE_BIT];
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////
  always_comb
  begin
    rdata = '0;
    case (reg_addr_i)
      can_pkg::ADDR_MODE:
      begin
        rdata[can_pkg::MODE_RESET_BIT]  = reset_mode_o;
        rdata[can_pkg::MODE_IRQ_EN_BIT] = irq_en;
      end
      can_pkg::ADDR_STATUS:
      begin
        rdata[can_pkg::STATUS_TX_BUSY_BIT] = tx_busy_i;
        rdata[can_pkg::STATUS_RX_BUSY_BIT] = rx_busy_i;
        rdata[can_pkg::STATUS_RX_DONE_BIT] = rx_done_i;
        rdata[can_pkg::STATUS_CRC_OK_BIT]  = crc_ok_i;
      end
      can_pkg::ADDR_BTR:
      begin
        rdata[can_pkg::BTR_PRESC_LSB +: can_pkg::PRESC_W] = presc_o;
        rdata[can_pkg::BTR_PROP_LSB  +: can_pkg::SEG_W]   = prop_seg_o;
        rdata[can_pkg::BTR_PH1_LSB   +: can_pkg::SEG_W]   = phase_seg_1_o;
        rdata[can_pkg::BTR_PH2_LSB   +: can_pkg::SEG_W]   = phase_seg_2_o;
      end
      can_pkg::ADDR_LEN:    rdata[can_pkg::LEN_W-1:0] = frame_len_o;
      can_pkg::ADDR_TX_LO:  rdata = tx_data_o[can_pkg::REG_DATA_W-1:0];
      can_pkg::ADDR_TX_HI:  rdata = tx_data_o[can_pkg::MAX_DATA_BITS-1:can_pkg::REG_DATA_W];
      can_pkg::ADDR_RX_LO:  rdata = rx_data_i[can_pkg::REG_DATA_W-1:0];
      can_pkg::ADDR_RX_HI:  rdata = rx_data_i[can_pkg::MAX_DATA_BITS-1:can_pkg::REG_DATA_W];
      can_pkg::ADDR_RX_CRC: rdata[can_pkg::CRC_W-1:0] = rx_crc_i;
      // Command and unmapped words read zero
      default:              rdata = '0;
    endcase
  end

  // Read data lands one clock after the strobe, then holds
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
      reg_data_o <= '0;
    else if (reg_re_i)
      reg_data_o <= rdata;
  end

endmodule

/* can_tb.sv */
//////////////////////////////
// CAN controller testbench
// Register access, loopback frame timing and
// decode, reception and CRC error detection
//////////////////////////////

`timescale 1ns/100ps

module can_tb;

  localparam int          CLK_HALF   = 50;
  localparam int          WAIT_LIMIT = 20000;
  localparam logic [15:0] SEED       = 16'd5222;

  logic                           clk_i;
  logic                           rst;
  logic                           reg_re_i;
  logic                           reg_we_i;
  logic [can_pkg::REG_ADDR_W-1:0] reg_addr_i;
  logic [can_pkg::REG_DATA_W-1:0] reg_data_i;
  logic [can_pkg::REG_DATA_W-1:0] reg_data_o;
  logic                           rx_i;
  logic                           tx_o;
  logic                           irq_o;

  // Bus source select and tx_o recorder
  logic        loopback;
  logic        drv_rx;
  logic        capture_on;
  logic        tx_log[$];
  logic [15:0] lfsr;
  int          error_count;

  // Frame settings
  int          presc;
  int          prop;
  int          ph1;
  int          ph2;
  int          bit_clks;
  int          frame_len;
  logic [31:0] btr_val;
  logic [63:0] rnd;
  logic [63:0] tx_word;
  logic [63:0] exp_data;
  logic [14:0] exp_crc;
  logic [14:0] bad_crc;
  logic [31:0] status_rd;

  can_top #(
    .SYNC_STAGES (2)
  ) uut (
    .clk_i      (clk_i),
    .rst        (rst),
    .reg_re_i   (reg_re_i),
    .reg_we_i   (reg_we_i),
    .reg_addr_i (reg_addr_i),
    .reg_data_i (reg_data_i),
    .reg_data_o (reg_data_o),
    .rx_i       (rx_i),
    .tx_o       (tx_o),
    .irq_o      (irq_o)
  );

  assign rx_i = loopback ? tx_o : drv_rx;

  always #CLK_HALF clk_i = ~clk_i;

  // One tx_o sample per clock, taken mid-cycle
  always @(negedge clk_i)
  begin
    if (capture_on)
      tx_log.push_back(tx_o);
  end

  //////////////////////////////
  // Random source and reference
  //////////////////////////////
  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val  = {val[62:0], lfsr[0]};
    end
  endtask

  // CAN CRC-15 over data bits len-1 down to 0, start value zero
  function automatic logic [14:0] ref_crc15(input logic [63:0] data, input int len);
    logic [14:0] crc;
    logic        fb;
    crc = '0;
    for (int i = len - 1; i >= 0; i--)
    begin
      fb  = data[i] ^ crc[14];
      crc = {crc[13:0], 1'b0};
      if (fb)
        crc = crc ^ 15'h4599;
    end
    return crc;
  endfunction

  function automatic logic [63:0] len_mask(input int len);
    return (len >= 64) ? '1 : ((64'd1 << len) - 64'd1);
  endfunction

  //////////////////////////////
  // Checks and bus tasks
  //////////////////////////////
  task automatic end_with_failure();
    error_count++;
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    reg_we_i   = 1'b1;
    reg_addr_i = addr;
    reg_data_i = data;
    @(negedge clk_i);
    reg_we_i   = 1'b0;
  endtask

  // Read data is valid one clock after the strobe
  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge clk_i);
    reg_re_i   = 1'b1;
    reg_addr_i = addr;
    @(negedge clk_i);
    reg_re_i = 1'b0;
    data     = reg_data_o;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] rd;
    reg_read(addr, rd);
    check_value(name, rd, exp);
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (irq_o !== level && n < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (irq_o !== level)
    begin
      $display("Timed out waiting for irq_o to become %0b", level);
      end_with_failure();
    end
  endtask

  task automatic wait_status(input int bit_idx, input logic level);
    logic [31:0] st;
    int          n;
    n = 0;
    reg_read(can_pkg::ADDR_STATUS, st);
    while (st[bit_idx] !== level && n < WAIT_LIMIT)
    begin
      reg_read(can_pkg::ADDR_STATUS, st);
      n++;
    end
    if (st[bit_idx] !== level)
    begin
      $display("Timed out polling STATUS bit %0d for value %0b", bit_idx, level);
      end_with_failure();
    end
  endtask

  // Start bit, data MSB first, CRC field, each held one bit time
  task automatic drive_frame(input logic [63:0] data, input int len, input logic [14:0] crc);
    for (int k = 0; k < len + 16; k++)
    begin
      if (k == 0)
        drv_rx = 1'b0;
      else if (k <= len)
        drv_rx = data[len-k];
      else
        drv_rx = crc[15-(k-len)];
      repeat (bit_clks) @(negedge clk_i);
    end
    drv_rx = 1'b1;
  endtask

  // Edge spacing and mid-bit decode of the recorded tx_o
  task automatic check_tx_frame(input logic [63:0] data, input int len,
                                input logic [14:0] crc);
    int          falls[$];
    int          f0;
    int          mid;
    logic [63:0] dec_data;
    logic [14:0] dec_crc;
    for (int i = 1; i < tx_log.size(); i++)
      if (tx_log[i-1] && !tx_log[i])
        falls.push_back(i);
    if (falls.size() == 0)
    begin
      $display("No falling edge seen on tx_o during the frame");
      end_with_failure();
    end
    for (int i = 1; i < falls.size(); i++)
      check_value("tx_o edge gap mod bit time", (falls[i] - falls[i-1]) % bit_clks, 0);
    f0  = falls[0];
    mid = bit_clks / 2;
    if (f0 + (len + 16) * bit_clks + mid >= tx_log.size())
    begin
      $display("Capture of tx_o ended before the frame did");
      end_with_failure();
    end
    dec_data = '0;
    dec_crc  = '0;
    check_value("tx_o start bit", tx_log[f0+mid], 0);
    for (int k = 1; k <= len; k++)
      dec_data = {dec_data[62:0], tx_log[f0+k*bit_clks+mid]};
    for (int k = len + 1; k <= len + 15; k++)
      dec_crc = {dec_crc[13:0], tx_log[f0+k*bit_clks+mid]};
    check_value("tx_o data bits", dec_data, data);
    check_value("tx_o crc bits", dec_crc, crc);
    check_value("tx_o after frame", tx_log[f0+(len+16)*bit_clks+mid], 1);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial
  begin
    clk_i       = 1'b0;
    rst         = 1'b1;
    reg_re_i    = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_data_i  = '0;
    loopback    = 1'b1;
    drv_rx      = 1'b1;
    capture_on  = 1'b0;
    lfsr        = SEED;
    error_count = 0;
    repeat (3) @(negedge clk_i);
    rst = 1'b0;

    // Reset values
    check_value("tx_o", tx_o, 1);
    check_value("irq_o", irq_o, 0);
    read_check(can_pkg::ADDR_MODE, 32'h1, "MODE");
    read_check(can_pkg::ADDR_STATUS, 32'h0, "STATUS");

    // Readback in reset mode, masked to field widths
    draw_bits(32, rnd);
    reg_write(can_pkg::ADDR_BTR, rnd[31:0]);
    read_check(can_pkg::ADDR_BTR, rnd[31:0] & 32'h3F3F_3F7F, "BTR");
    draw_bits(32, rnd);
    reg_write(can_pkg::ADDR_LEN, rnd[31:0]);
    read_check(can_pkg::ADDR_LEN, rnd[31:0] & 32'h7F, "LEN");
    draw_bits(64, rnd);
    reg_write(can_pkg::ADDR_TX_LO, rnd[31:0]);
    reg_write(can_pkg::ADDR_TX_HI, rnd[63:32]);
    read_check(can_pkg::ADDR_TX_LO, rnd[31:0], "TX_LO");
    read_check(can_pkg::ADDR_TX_HI, rnd[63:32], "TX_HI");

    // Random timing, prescaler at least 1 keeps the sample after the sync lag
    draw_bits(2, rnd);
    presc = 1 + int'(rnd[1:0]);
    draw_bits(2, rnd);
    prop = int'(rnd[1:0]);
    draw_bits(2, rnd);
    ph1 = int'(rnd[1:0]);
    draw_bits(2, rnd);
    ph2 = int'(rnd[1:0]);
    draw_bits(6, rnd);
    frame_len = 1 + int'(rnd[5:0]);
    bit_clks  = (presc + 1) * (prop + ph1 + ph2 + 4);
    btr_val   = presc | (prop << 8) | (ph1 << 16) | (ph2 << 24);
    draw_bits(64, tx_word);
    reg_write(can_pkg::ADDR_BTR, btr_val);
    reg_write(can_pkg::ADDR_LEN, frame_len);
    reg_write(can_pkg::ADDR_TX_LO, tx_word[31:0]);
    reg_write(can_pkg::ADDR_TX_HI, tx_word[63:32]);

    // Leave reset mode with irq enabled, BTR now locked
    reg_write(can_pkg::ADDR_MODE, 32'h2);
    read_check(can_pkg::ADDR_MODE, 32'h2, "MODE");
    reg_write(can_pkg::ADDR_BTR, ~btr_val);
    read_check(can_pkg::ADDR_BTR, btr_val, "BTR locked");

    // Loopback frame
    exp_data = tx_word & len_mask(frame_len);
    exp_crc  = ref_crc15(tx_word, frame_len);
    capture_on <= 1'b1;
    reg_write(can_pkg::ADDR_CMD, 32'h1);
    wait_irq(1'b1);
    wait_status(can_pkg::STATUS_TX_BUSY_BIT, 1'b0);
    repeat (2 * bit_clks) @(negedge clk_i);
    capture_on <= 1'b0;
    @(negedge clk_i);
    check_tx_frame(exp_data, frame_len, exp_crc);
    read_check(can_pkg::ADDR_STATUS, (32'd1 << can_pkg::STATUS_RX_DONE_BIT) |
               (32'd1 << can_pkg::STATUS_CRC_OK_BIT), "STATUS");
    read_check(can_pkg::ADDR_RX_LO, exp_data[31:0], "RX_LO");
    read_check(can_pkg::ADDR_RX_HI, exp_data[63:32], "RX_HI");
    read_check(can_pkg::ADDR_RX_CRC, {17'd0, exp_crc}, "RX_CRC");

    // Release clears done and irq, crc_ok keeps the last frame's result
    reg_write(can_pkg::ADDR_CMD, 32'h2);
    wait_irq(1'b0);
    reg_read(can_pkg::ADDR_STATUS, status_rd);
    check_value("STATUS without crc_ok",
                status_rd & ~(32'd1 << can_pkg::STATUS_CRC_OK_BIT), 0);

    // Driven frame with one CRC bit flipped
    loopback = 1'b0;
    draw_bits(64, tx_word);
    exp_data = tx_word & len_mask(frame_len);
    exp_crc  = ref_crc15(tx_word, frame_len);
    draw_bits(4, rnd);
    bad_crc = exp_crc ^ (15'd1 << (int'(rnd[3:0]) % 15));
    repeat (bit_clks) @(negedge clk_i);
    drive_frame(tx_word, frame_len, bad_crc);
    wait_status(can_pkg::STATUS_RX_DONE_BIT, 1'b1);
    read_check(can_pkg::ADDR_STATUS, 32'd1 << can_pkg::STATUS_RX_DONE_BIT, "STATUS");
    read_check(can_pkg::ADDR_RX_LO, exp_data[31:0], "RX_LO");
    read_check(can_pkg::ADDR_RX_HI, exp_data[63:32], "RX_HI");
    read_check(can_pkg::ADDR_RX_CRC, {17'd0, bad_crc}, "RX_CRC");

    if (error_count == 0)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
      end_with_failure();
  end

endmodule

/* can_top.sv */
//////////////////////////////
// CAN controller top level
// Registers, bit timing, transmitter
// and receiver
//////////////////////////////

`timescale 1ns/100ps

module can_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                           clk_i,
  input  logic                           rst,
  // Register port
  input  logic                           reg_re_i,
  input  logic                           reg_we_i,
  input  logic [can_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [can_pkg::REG_DATA_W-1:0] reg_data_i,
  output logic [can_pkg::REG_DATA_W-1:0] reg_data_o,
  // CAN bus
  input  logic                           rx_i,
  output logic                           tx_o,
  output logic                           irq_o
);

  // Configuration
  logic            reset_mode;
  can_pkg::presc_t presc;
  can_pkg::seg_t   prop_seg;
  can_pkg::seg_t   phase_seg_1;
  can_pkg::seg_t   phase_seg_2;
  can_pkg::len_t   frame_len;
  can_pkg::data_t  tx_data;
  logic            tx_request;
  logic            rx_release;

  // Timing strobes
  logic            sample_point;
  logic            sampled_bit;
  logic            tx_point;

  // Bit-stream status
  logic            tx_busy;
  logic            rx_busy;
  logic            rx_done;
  logic            crc_ok;
  can_pkg::data_t  rx_data;
  can_pkg::crc_t   rx_crc;

  can_regs i_can_regs (
    .clk_i         (clk_i),
    .rst           (rst),
    .reg_re_i      (reg_re_i),
    .reg_we_i      (reg_we_i),
    .reg_addr_i    (reg_addr_i),
    .reg_data_i    (reg_data_i),
    .reg_data_o    (reg_data_o),
    .tx_busy_i     (tx_busy),
    .rx_busy_i     (rx_busy),
    .rx_done_i     (rx_done),
    .crc_ok_i      (crc_ok),
    .rx_data_i     (rx_data),
    .rx_crc_i      (rx_crc),
    .reset_mode_o  (reset_mode),
    .presc_o       (presc),
    .prop_seg_o    (prop_seg),
    .phase_seg_1_o (phase_seg_1),
    .phase_seg_2_o (phase_seg_2),
    .frame_len_o   (frame_len),
    .tx_data_o     (tx_data),
    .tx_request_o  (tx_request),
    .rx_release_o  (rx_release),
    .irq_o         (irq_o)
  );

  // Synchronized level only feeds sampling inside the timing block
  can_btl #(
    .SYNC_STAGES (SYNC_STAGES)
  ) i_can_btl (
    .clk_i          (clk_i),
    .rst            (rst),
    .rx_i           (rx_i),
    .reset_mode_i   (reset_mode),
    .presc_i        (presc),
    .prop_seg_i     (prop_seg),
    .phase_seg_1_i  (phase_seg_1),
    .phase_seg_2_i  (phase_seg_2),
    .tx_busy_i      (tx_busy),
    .rx_busy_i      (rx_busy),
    .rx_sync_o      (),
    .sample_point_o (sample_point),
    .sampled_bit_o  (sampled_bit),
    .tx_point_o     (tx_point)
  );

  can_bit_tx i_can_bit_tx (
    .clk_i        (clk_i),
    .rst          (rst),
    .tx_request_i (tx_request),
    .tx_point_i   (tx_point),
    .frame_len_i  (frame_len),
    .tx_data_i    (tx_data),
    .tx_o         (tx_o),
    .tx_busy_o    (tx_busy)
  );

  can_bit_rx i_can_bit_rx (
    .clk_i          (clk_i),
    .rst            (rst),
    .sample_point_i (sample_point),
    .sampled_bit_i  (sampled_bit),
    .frame_len_i    (frame_len),
    .rx_release_i   (rx_release),
    .rx_busy_o      (rx_busy),
    .rx_done_o      (rx_done),
    .crc_ok_o       (crc_ok),
    .rx_data_o      (rx_data),
    .rx_crc_o       (rx_crc)
  );

endmodule

/* flist.f */
can_pkg.sv
can_crc15.sv
can_regs.sv
can_btl.sv
can_bit_tx.sv
can_bit_rx.sv
can_top.sv
can_tb.sv
